//--- source/pingpong_pkg.sv
package pingpong_pkg;

    typedef logic [3:0] count_t;   // counter value and both bounds
    typedef logic [6:0] seg_t;     // active low, bit 0 drives segment a
    typedef logic [3:0] anode_t;   // active low digit enables

    typedef enum logic [1:0] {
        DIGIT_DIR_LO = 2'd0,
        DIGIT_DIR_HI = 2'd1,
        DIGIT_ONES   = 2'd2,
        DIGIT_TENS   = 2'd3
    } digit_t;

    typedef struct packed {
        count_t count;
        logic   up;     // 1 while counting up
    } counter_state_t;

    typedef struct packed {
        logic clear;
        logic flip;
    } press_t;

    typedef struct packed {
        logic step;
        logic scan;
    } tick_t;

    localparam int DEBOUNCE_LEN = 16;
    localparam int STEP_BITS    = 26;   // roughly 0.67 s per step at 100 MHz
    localparam int SCAN_BITS    = 16;

    localparam seg_t SEG_UP   = 7'b1011100;
    localparam seg_t SEG_DOWN = 7'b1100011;

    // index is the decimal digit
    localparam seg_t SEG_DIGIT [10] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
        7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000
    };

endpackage

//--- source/button_conditioner.sv
`timescale 1ns/1ns

module button_conditioner #(
    parameter int debounce_len = pingpong_pkg::DEBOUNCE_LEN
) (
    input  logic clk,
    input  logic rst,
    input  logic button,
    output logic press
);

    logic [debounce_len-1:0] history;
    logic                    level;
    logic                    level_q;

    // the button counts as pressed only after a full window of high samples
    assign level = &history;

    always_ff @(posedge clk) begin
        if (rst) begin
            history <= '0;
        end else begin
            history <= {history[debounce_len-2:0], button};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            level_q <= 1'b0;
            press   <= 1'b0;
        end else begin
            level_q <= level;
            press   <= level & ~level_q;   // one cycle on the debounced rising edge
        end
    end

    // a held button gives one press, never a train of them
    assert property (@(posedge clk) disable iff (rst) press |=> !press)
        else $error("press strobe lasted more than one cycle");

endmodule

//--- source/tick_generator.sv
`timescale 1ns/1ns

module tick_generator #(
    parameter int step_bits = pingpong_pkg::STEP_BITS,
    parameter int scan_bits = pingpong_pkg::SCAN_BITS
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                restart,
    output pingpong_pkg::tick_t ticks
);

    logic [step_bits-1:0] step_cnt;
    logic [scan_bits-1:0] scan_cnt;

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            step_cnt <= '0;
            scan_cnt <= '0;
            ticks    <= '0;
        end else begin
            step_cnt   <= step_cnt + 1'b1;
            scan_cnt   <= scan_cnt + 1'b1;
            ticks.step <= &step_cnt;   // strobe lines up with the wrap to zero
            ticks.scan <= &scan_cnt;
        end
    end

endmodule

//--- source/pingpong_counter.sv
`timescale 1ns/1ns

module pingpong_counter (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         enable,
    input  pingpong_pkg::count_t         min_bound,
    input  pingpong_pkg::count_t         max_bound,
    input  logic                         step,
    input  pingpong_pkg::press_t         presses,
    output pingpong_pkg::counter_state_t state
);

    import pingpong_pkg::*;

    counter_state_t next;
    logic           allowed;

    // the count freezes outside the bounds and when the bounds collapse to one value
    assign allowed = enable
                  && (state.count >= min_bound)
                  && (state.count <= max_bound)
                  && (min_bound != max_bound);

    always_comb begin
        next = state;
        if (allowed) begin
            if (step) begin
                if (state.count == max_bound) begin
                    next.count = state.count - 1'b1;
                    next.up    = 1'b0;
                end else if (state.count == min_bound) begin
                    next.count = state.count + 1'b1;
                    next.up    = 1'b1;
                end else if (presses.flip) begin
                    // reverse now and take this step the other way
                    next.count = state.up ? state.count - 1'b1 : state.count + 1'b1;
                    next.up    = ~state.up;
                end else begin
                    next.count = state.up ? state.count + 1'b1 : state.count - 1'b1;
                end
            end else if (presses.flip) begin
                next.up = ~state.up;   // no step this cycle, so only the direction turns
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || presses.clear) begin
            state.count <= min_bound;
            state.up    <= 1'b1;
        end else begin
            state <= next;
        end
    end

    property step_stays_in_range;
        @(posedge clk) disable iff (rst)
            (allowed && step && !presses.clear)
            |=> (state.count >= $past(min_bound)) && (state.count <= $past(max_bound));
    endproperty

    assert property (step_stays_in_range)
        else $error("step left the range, count %h", state.count);

endmodule

//--- source/display_scanner.sv
`timescale 1ns/1ns

module display_scanner (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         scan,
    input  pingpong_pkg::counter_state_t state,
    output pingpong_pkg::anode_t         anodes,
    output pingpong_pkg::seg_t           segs
);

    import pingpong_pkg::*;

    digit_t digit;
    count_t ones;
    logic   tens;
    seg_t   dir_glyph;
    seg_t   seg_next;

    assign tens      = (state.count > 4'd9);
    assign ones      = tens ? state.count - 4'd10 : state.count;
    assign dir_glyph = state.up ? SEG_UP : SEG_DOWN;

    always_comb begin
        case (digit)
            DIGIT_DIR_LO: seg_next = dir_glyph;
            DIGIT_DIR_HI: seg_next = dir_glyph;
            DIGIT_ONES:   seg_next = SEG_DIGIT[ones];
            default:      seg_next = SEG_DIGIT[tens ? 1 : 0];
        endcase
    end

    // scan order runs from the rightmost digit to the left
    always_ff @(posedge clk) begin
        if (rst) begin
            digit <= DIGIT_DIR_LO;
        end else if (scan) begin
            case (digit)
                DIGIT_DIR_LO: digit <= DIGIT_DIR_HI;
                DIGIT_DIR_HI: digit <= DIGIT_ONES;
                DIGIT_ONES:   digit <= DIGIT_TENS;
                default:      digit <= DIGIT_DIR_LO;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            anodes <= 4'b1110;
            segs   <= SEG_UP;   // counter comes out of reset counting up
        end else begin
            anodes <= ~(anode_t'(1) << digit);
            segs   <= seg_next;
        end
    end

    // two lit digits would mix their segments on the board
    assert property (@(posedge clk) disable iff (rst) $onehot(~anodes))
        else $error("anodes %h do not select exactly one digit", anodes);

endmodule

//--- source/pingpong_top.sv
`timescale 1ns/1ns

module pingpong_top #(
    parameter int debounce_len = pingpong_pkg::DEBOUNCE_LEN,
    parameter int step_bits    = pingpong_pkg::STEP_BITS,
    parameter int scan_bits    = pingpong_pkg::SCAN_BITS
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 enable,
    input  logic                 clear_button,
    input  logic                 flip_button,
    input  pingpong_pkg::count_t min_bound,
    input  pingpong_pkg::count_t max_bound,
    output pingpong_pkg::anode_t anodes,
    output pingpong_pkg::seg_t   segs
);

    import pingpong_pkg::*;

    wire press_t    presses;   // each field comes from its own conditioner
    tick_t          ticks;
    counter_state_t state;

    button_conditioner #(.debounce_len(debounce_len)) clear_cond (
        .clk    (clk),
        .rst    (rst),
        .button (clear_button),
        .press  (presses.clear)
    );

    button_conditioner #(.debounce_len(debounce_len)) flip_cond (
        .clk    (clk),
        .rst    (rst),
        .button (flip_button),
        .press  (presses.flip)
    );

    tick_generator #(.step_bits(step_bits), .scan_bits(scan_bits)) ticker (
        .clk     (clk),
        .rst     (rst),
        .restart (presses.clear),   // clear also restarts both dividers
        .ticks   (ticks)
    );

    pingpong_counter counter (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .min_bound (min_bound),
        .max_bound (max_bound),
        .step      (ticks.step),
        .presses   (presses),
        .state     (state)
    );

    display_scanner scanner (
        .clk    (clk),
        .rst    (rst),
        .scan   (ticks.scan),
        .state  (state),
        .anodes (anodes),
        .segs   (segs)
    );

endmodule

//--- dv/pingpong_model.svh
`ifndef PINGPONG_MODEL_SVH
`define PINGPONG_MODEL_SVH

// active low, bit 0 is segment a, indexed by the decimal digit
localparam logic [6:0] DECIMAL_GLYPHS [10] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78, 7'h00, 7'h10
};

logic [31:0]   rng_state;
logic [DL-1:0] m_hist [2];   // index 0 follows clear, 1 follows flip
logic [1:0]    m_level_q;
logic [1:0]    m_press;
logic [SB-1:0] m_step_cnt;
logic [CB-1:0] m_scan_cnt;
logic          m_step;
logic          m_scan;
count_t        m_count;
logic          m_up;
logic [1:0]    m_digit;
anode_t        exp_anodes;
seg_t          exp_segs;

function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic int unsigned pick(input int unsigned n);
    rng_state = xorshift(rng_state);
    return rng_state % n;
endfunction

// one rising edge of the whole design, every register taken from its old value
task automatic model_clock(input logic r, input logic en, input count_t lo, input count_t hi,
                           input logic [1:0] buttons);
    count_t count_n;
    logic   up_n;
    logic   allowed;
    int     i;
    count_n = m_count;
    up_n    = m_up;
    allowed = en && (m_count >= lo) && (m_count <= hi) && (lo != hi);
    if (r || m_press[0]) begin
        count_n = lo;
        up_n    = 1'b1;
    end else if (allowed && m_step) begin
        if (m_count == hi) begin
            count_n = m_count - 4'd1;
            up_n    = 1'b0;
        end else if (m_count == lo) begin
            count_n = m_count + 4'd1;
            up_n    = 1'b1;
        end else begin
            up_n    = m_up ^ m_press[1];   // a flip sends this step the other way
            count_n = up_n ? m_count + 4'd1 : m_count - 4'd1;
        end
    end else if (allowed) begin
        up_n = m_up ^ m_press[1];
    end

    // the display registers show the digit and the count from before this edge
    if (r) begin
        exp_anodes = 4'b1110;
        exp_segs   = SEG_UP;
        m_digit    = 2'd0;
    end else begin
        case (m_digit)
            2'd0:    exp_anodes = 4'b1110;
            2'd1:    exp_anodes = 4'b1101;
            2'd2:    exp_anodes = 4'b1011;
            default: exp_anodes = 4'b0111;
        endcase
        exp_segs   = (m_digit < 2'd2)  ? (m_up ? SEG_UP : SEG_DOWN)
                   : (m_digit == 2'd2) ? DECIMAL_GLYPHS[int'(m_count) % 10]
                   : DECIMAL_GLYPHS[int'(m_count) / 10];
        m_digit    = m_digit + 2'(m_scan);
    end

    if (r || m_press[0]) begin
        m_step_cnt = '0;
        m_scan_cnt = '0;
        m_step     = 1'b0;
        m_scan     = 1'b0;
    end else begin
        m_step     = &m_step_cnt;
        m_scan     = &m_scan_cnt;
        m_step_cnt = m_step_cnt + SB'(1);
        m_scan_cnt = m_scan_cnt + CB'(1);
    end

    m_count = count_n;
    m_up    = up_n;

    for (i = 0; i < 2; i++) begin
        if (r) begin
            m_hist[i]    = '0;
            m_level_q[i] = 1'b0;
            m_press[i]   = 1'b0;
        end else begin
            m_press[i]   = &m_hist[i] & ~m_level_q[i];
            m_level_q[i] = &m_hist[i];
            m_hist[i]    = {m_hist[i][DL-2:0], buttons[i]};
        end
    end
endtask

`endif

//--- dv/pingpong_tb.sv
`timescale 1ns/1ns

module pingpong_tb;

    import pingpong_pkg::*;

    localparam int DL           = 4;
    localparam int SB           = 4;
    localparam int CB           = 1;
    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 4;
    localparam int TEST_CYCLES  = 400;
    localparam int NUM_TESTS    = 6;
    localparam int WATCHDOG_NS  = NUM_TESTS * (RESET_CYCLES + TEST_CYCLES) * CLK_PERIOD
                                + 20 * CLK_PERIOD;

    localparam int MODE_RESET = 0;
    localparam int MODE_TURN  = 1;
    localparam int MODE_FLIP  = 2;
    localparam int MODE_HOLD  = 3;
    localparam int MODE_CLEAR = 4;
    localparam int MODE_TENS  = 5;

    logic       clk;
    logic       rst;
    logic       enable;
    logic       clear_button;
    logic       flip_button;
    count_t     min_bound;
    count_t     max_bound;
    anode_t     anodes;
    seg_t       segs;
    logic [1:0] btn_level;
    int         btn_left [2];
    int         errors;
    int         failed;
    seg_t       ones_seen;
    int         ones_changes;

    `include "pingpong_model.svh"

    pingpong_top #(.debounce_len(DL), .step_bits(SB), .scan_bits(CB)) uut (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .clear_button (clear_button),
        .flip_button  (flip_button),
        .min_bound    (min_bound),
        .max_bound    (max_bound),
        .anodes       (anodes),
        .segs         (segs)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests finished");
        $display("sim failed");
        $finish;
    end

    task automatic advance_cycle();
        @(posedge clk);
        model_clock(rst, enable, min_bound, max_bound, {flip_button, clear_button});
        #1;
        assert (anodes === exp_anodes) else begin
            errors++;
            $display("mismatch anodes: got %h, expected %h at %0t", anodes, exp_anodes, $time);
        end
        assert (segs === exp_segs) else begin
            errors++;
            $display("mismatch segs: got %h, expected %h at %0t", segs, exp_segs, $time);
        end
        // a step moves the count by one, so the ones digit changes with every move
        if (anodes === 4'b1011 && segs !== ones_seen) begin
            ones_changes++;
            ones_seen = segs;
        end
        #(DRIVE_DELAY - 1);
    endtask

    // low gaps alternate with high bursts that are either glitches or real presses
    task automatic shape_button(input int i, input logic active);
        if (!active) begin
            btn_level[i] = 1'b0;
            btn_left[i]  = 0;
        end else if (btn_left[i] > 0) begin
            btn_left[i]--;
        end else begin
            btn_level[i] = ~btn_level[i];
            if (!btn_level[i])
                btn_left[i] = 1 + int'(pick(20));
            else if (pick(2) == 0)
                btn_left[i] = int'(pick(DL - 1));   // high for fewer than DL samples
            else
                btn_left[i] = DL + int'(pick(12));
        end
    endtask

    task automatic drive_inputs(input int mode);
        logic [1:0] active;
        int         i;
        active = 2'b00;
        case (mode)
            MODE_FLIP, MODE_TENS: active = 2'b10;
            MODE_CLEAR:           active = 2'b11;
            MODE_HOLD: begin
                active = 2'b10;
                if (pick(6) == 0)
                    enable = ~enable;
                if (pick(40) == 0) begin   // new bounds may leave the count outside
                    min_bound = count_t'(pick(16));
                    max_bound = count_t'(pick(16));
                end
            end
            default: active = 2'b00;
        endcase
        for (i = 0; i < 2; i++)
            shape_button(i, active[i]);
        clear_button = btn_level[0];
        flip_button  = btn_level[1];
    endtask

    task automatic run_test(input string name, input int mode);
        int errors_before;
        int lo;
        errors_before = errors;
        if (mode == MODE_TENS) begin
            lo        = int'(pick(8));
            max_bound = count_t'(10 + pick(6));
        end else if (mode == MODE_RESET || mode == MODE_HOLD) begin
            lo        = int'(pick(16));
            max_bound = count_t'(pick(16));
        end else begin
            lo        = int'(pick(12));
            max_bound = count_t'(lo + 2 + int'(pick(14 - lo)));
        end
        min_bound    = count_t'(lo);
        ones_seen    = DECIMAL_GLYPHS[lo % 10];
        ones_changes = 0;
        enable       = (mode != MODE_RESET);
        btn_level    = 2'b00;
        btn_left     = '{0, 0};
        clear_button = 1'b0;
        flip_button  = 1'b0;
        rst          = 1'b1;
        repeat (RESET_CYCLES) advance_cycle();
        rst = 1'b0;
        repeat (TEST_CYCLES) begin
            drive_inputs(mode);
            advance_cycle();
        end
        if (mode == MODE_TURN) begin
            assert (ones_changes > 0) else begin
                errors++;
                $display("displayed count never moved during the turnaround test");
            end
        end
        if (errors != errors_before)
            failed++;
        $display("test %s: %0d cycles, %0d errors", name, RESET_CYCLES + TEST_CYCLES,
                 errors - errors_before);
    endtask

    initial begin
        rst          = 1'b1;
        enable       = 1'b0;
        clear_button = 1'b0;
        flip_button  = 1'b0;
        min_bound    = '0;
        max_bound    = '0;
        btn_level    = 2'b00;
        btn_left     = '{0, 0};
        rng_state    = 32'hf2164a38;
        errors       = 0;
        failed       = 0;
        run_test("reset_display", MODE_RESET);
        run_test("turnaround", MODE_TURN);
        run_test("flip", MODE_FLIP);
        run_test("hold", MODE_HOLD);
        run_test("clear", MODE_CLEAR);
        run_test("tens_digit", MODE_TENS);
        $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+dv
source/pingpong_pkg.sv
source/button_conditioner.sv
source/tick_generator.sv
source/pingpong_counter.sv
source/display_scanner.sv
source/pingpong_top.sv
dv/pingpong_tb.sv

//--- Makefile
# Verilator flow for the ping-pong counter testbench

VERILATOR ?= verilator
TOP       ?= pingpong_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
